// ==== source/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  // Cache geometry
  localparam int way_count   = 4;
  localparam int set_count   = 8;
  localparam int word_bits   = 32;
  localparam int line_words  = 8;                 // Also beats per burst
  localparam int line_bits   = 256;
  localparam int offset_bits = 5;                 // Byte offset in line
  localparam int index_bits  = 3;
  localparam int tag_bits    = 24;
  localparam int way_bits    = 2;
  localparam int stamp_bits  = 4;
  localparam int stamp_max   = 15;                // Stamp counter saturates here

  typedef logic [31:0]              addr_t;
  typedef logic [word_bits-1:0]     word_t;
  typedef logic [word_bits/8-1:0]   strb_t;
  typedef logic [line_bits-1:0]     line_t;       // Word 0 in the low bits
  typedef logic [tag_bits-1:0]      tag_t;
  typedef logic [index_bits-1:0]    index_t;
  typedef logic [way_bits-1:0]      way_t;
  typedef logic [stamp_bits-1:0]    stamp_t;
  typedef logic [way_count-1:0]     way_vec_t;

  // Per way, per set status
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } meta_t;

  // CPU request, held until req_ready
  typedef struct packed {
    logic  write;                                 // 1 for a store
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } cpu_req_t;

  // Lookup result from the store
  typedef struct packed {
    logic     hit;
    way_t     hit_way;
    line_t    hit_line;                           // Victim line when no way hits
    way_vec_t way_valid;
    way_vec_t way_dirty;
  } lookup_t;

  // Write order to the store
  typedef struct packed {
    logic wr_hit;                                 // Merge CPU word into hit way
    logic wr_fill;                                // Shift one refill beat into fill_way
    way_t fill_way;
  } store_cmd_t;

  typedef enum logic [2:0] {
    idle, read_hit, write_hit, send_data, wb_req, wb_data, fill_req, fill_data
  } state_t;

  // Address field helpers
  function automatic index_t addr_index(addr_t a);
    return a[offset_bits +: index_bits];
  endfunction

  function automatic tag_t addr_tag(addr_t a);
    return a[offset_bits + index_bits +: tag_bits];
  endfunction

  function automatic logic [offset_bits-3:0] addr_word(addr_t a);
    return a[offset_bits-1:2];                    // Word within the line
  endfunction

  function automatic addr_t line_base(addr_t a);
    return a & ~addr_t'((1 << offset_bits) - 1);
  endfunction

endpackage

`default_nettype wire

// ==== source/cache_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_array #(
  parameter type payload_t = logic
) (
  input  logic                clk,
  input  logic                rst,
  input  dcache_pkg::index_t  index,
  input  logic                wen,
  input  payload_t            wdata,
  output payload_t            rdata
);
  import dcache_pkg::*;

  payload_t mem [set_count];                      // One entry per set

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < set_count; s++) begin
        mem[s] <= '0;                             // Invalid and clean after reset
      end
    end else if (wen) begin
      mem[index] <= wdata;
    end
  end

  assign rdata = mem[index];                      // Combinational read

endmodule

`default_nettype wire

// ==== source/way_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module way_store (
  input  logic                                          clk,
  input  logic                                          rst,
  input  dcache_pkg::cpu_req_t                          req,
  input  dcache_pkg::store_cmd_t                        cmd,
  input  dcache_pkg::word_t                             fill_data,
  output dcache_pkg::lookup_t                           lookup,
  output dcache_pkg::tag_t [dcache_pkg::way_count-1:0]  way_tags
);
  import dcache_pkg::*;

  index_t   index;
  tag_t     req_tag;
  meta_t    meta_rd [way_count];
  meta_t    meta_wr [way_count];
  line_t    line_rd [way_count];
  line_t    line_wr [way_count];
  way_vec_t wen;
  way_vec_t hit_vec;
  line_t    merged;                               // Hit line with CPU bytes applied

  assign index   = addr_index(req.addr);
  assign req_tag = addr_tag(req.addr);

  for (genvar w = 0; w < way_count; w++) begin : g_way
    assign hit_vec[w]  = meta_rd[w].valid && (meta_rd[w].tag == req_tag);
    assign way_tags[w] = meta_rd[w].tag;

    assign wen[w] = (cmd.wr_hit && (lookup.hit_way == way_t'(w))) ||
                    (cmd.wr_fill && (cmd.fill_way == way_t'(w)));

    // Fill installs the new tag clean, a store marks the line dirty
    assign meta_wr[w] = cmd.wr_fill ? meta_t'{valid: 1'b1, dirty: 1'b0, tag: req_tag}
                                    : meta_t'{valid: 1'b1, dirty: 1'b1, tag: meta_rd[w].tag};

    // Refill beats enter at the top, word 0 ends lowest after eight shifts
    assign line_wr[w] = cmd.wr_fill ? {fill_data, line_rd[w][line_bits-1:word_bits]} : merged;

    cache_array #(.payload_t(meta_t)) u_meta (
      .clk   (clk),
      .rst   (rst),
      .index (index),
      .wen   (wen[w]),
      .wdata (meta_wr[w]),
      .rdata (meta_rd[w])
    );

    cache_array #(.payload_t(line_t)) u_line (
      .clk   (clk),
      .rst   (rst),
      .index (index),
      .wen   (wen[w]),
      .wdata (line_wr[w]),
      .rdata (line_rd[w])
    );
  end

  always_comb begin
    way_t sel;
    lookup.hit     = |hit_vec;
    lookup.hit_way = '0;
    for (int w = way_count - 1; w >= 0; w--) begin
      if (hit_vec[w]) lookup.hit_way = way_t'(w);  // Lowest hitting way wins
    end
    sel = lookup.hit ? lookup.hit_way : cmd.fill_way;  // Victim line on a miss
    lookup.hit_line = line_rd[sel];
    for (int w = 0; w < way_count; w++) begin
      lookup.way_valid[w] = meta_rd[w].valid;
      lookup.way_dirty[w] = meta_rd[w].dirty;
    end
  end

  // Byte merge of the store word at the request offset
  always_comb begin
    merged = lookup.hit_line;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (req.wstrb[b]) begin
        merged[addr_word(req.addr) * word_bits + b * 8 +: 8] = req.wdata[b * 8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/lru_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module lru_select (
  input  logic                clk,
  input  logic                rst,
  input  dcache_pkg::index_t  index,
  input  logic                touch,
  input  dcache_pkg::way_t    touch_way,
  output dcache_pkg::way_t    victim
);
  import dcache_pkg::*;

  stamp_t stamps [set_count][way_count];          // Last access stamp per way
  stamp_t stamp_ctr;                              // Global access clock

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < set_count; s++) begin
        for (int w = 0; w < way_count; w++) begin
          stamps[s][w] <= '0;
        end
      end
    end else if (touch) begin
      stamps[index][touch_way] <= stamp_ctr;
    end
  end

  // Counter stops at the top value
  always_ff @(posedge clk) begin
    if (rst) begin
      stamp_ctr <= '0;
    end else if (touch && (stamp_ctr != stamp_t'(stamp_max))) begin
      stamp_ctr <= stamp_ctr + 1'b1;
    end
  end

  // Oldest stamp in the set, lowest way on a tie
  // Untouched ways sit at zero and are taken first
  always_comb begin
    stamp_t best;
    best   = stamps[index][0];
    victim = '0;
    for (int w = 1; w < way_count; w++) begin
      if (stamps[index][w] < best) begin      // Strict compare keeps lower way on tie
        best   = stamps[index][w];
        victim = way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          req_valid,
  input  dcache_pkg::cpu_req_t                          req,
  output logic                                          req_ready,
  output logic                                          rsp_valid,
  output dcache_pkg::word_t                             rsp_data,
  input  logic                                          rsp_ready,
  input  dcache_pkg::lookup_t                           lookup,
  input  dcache_pkg::tag_t [dcache_pkg::way_count-1:0]  way_tags,
  input  dcache_pkg::way_t                              victim,
  output dcache_pkg::store_cmd_t                        cmd,
  output logic                                          touch,
  output dcache_pkg::way_t                              touch_way,
  output logic                                          rd_req_valid,
  output dcache_pkg::addr_t                             rd_req_addr,
  input  logic                                          rd_req_ready,
  input  logic                                          rd_rsp_valid,
  input  dcache_pkg::word_t                             rd_rsp_data,
  input  logic                                          rd_rsp_last,
  output logic                                          rd_rsp_ready,
  output logic                                          wr_req_valid,
  output dcache_pkg::addr_t                             wr_req_addr,
  input  logic                                          wr_req_ready,
  output logic                                          wr_data_valid,
  output dcache_pkg::word_t                             wr_data,
  output logic                                          wr_data_last,
  input  logic                                          wr_data_ready
);
  import dcache_pkg::*;

  state_t                         state;
  state_t                         state_nxt;
  way_t                           victim_q;       // Way chosen at the miss
  line_t                          wb_buf;         // Write-back shift buffer
  logic [$clog2(line_words)-1:0]  beat_cnt;
  logic                           beat_last;
  word_t                          hit_word;

  assign beat_last = &beat_cnt;                   // Eighth beat
  assign hit_word  = lookup.hit_line[addr_word(req.addr) * word_bits +: word_bits];

  always_comb begin
    state_nxt = state;
    case (state)
      idle: begin
        if (req_valid) begin
          if (lookup.hit) begin
            state_nxt = req.write ? write_hit : read_hit;
          end else if (lookup.way_valid[victim] && lookup.way_dirty[victim]) begin
            state_nxt = wb_req;                   // Dirty victim goes out first
          end else begin
            state_nxt = fill_req;
          end
        end
      end
      read_hit:  state_nxt = send_data;
      write_hit: state_nxt = idle;
      send_data: if (rsp_ready) state_nxt = idle;
      wb_req:    if (wr_req_ready) state_nxt = wb_data;
      wb_data:   if (wr_data_ready && beat_last) state_nxt = fill_req;
      fill_req:  if (rd_req_ready) state_nxt = fill_data;
      fill_data: begin
        if (rd_rsp_valid && rd_rsp_last) begin
          state_nxt = req.write ? write_hit : read_hit;  // Finish as a hit
        end
      end
      default:   state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      victim_q <= '0;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == idle && req_valid && !lookup.hit) begin
        victim_q <= victim;
      end
      // Counts write-back beats only
      if (state == wb_req && wr_req_ready) begin
        beat_cnt <= '0;
      end else if (state == wb_data && wr_data_ready) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // Data path registers
  always_ff @(posedge clk) begin
    if (state == wb_req && wr_req_ready) begin
      wb_buf <= lookup.hit_line;                  // Victim line, no way hits here
    end else if (state == wb_data && wr_data_ready) begin
      wb_buf <= {{word_bits{1'b0}}, wb_buf[line_bits-1:word_bits]};
    end

    if (state == read_hit) begin
      rsp_data <= hit_word;
    end
  end

  // CPU side
  assign req_ready = (state == read_hit) || (state == write_hit);
  assign rsp_valid = state == send_data;
  assign touch     = req_ready;                   // Both hit states update LRU
  assign touch_way = lookup.hit_way;

  always_comb begin
    cmd.wr_hit   = state == write_hit;
    cmd.wr_fill  = (state == fill_data) && rd_rsp_valid;
    cmd.fill_way = victim_q;
  end

  // Memory side
  assign rd_req_valid  = state == fill_req;
  assign rd_req_addr   = line_base(req.addr);
  assign rd_rsp_ready  = state == fill_data;
  assign wr_req_valid  = state == wb_req;
  assign wr_req_addr   = {way_tags[victim_q], addr_index(req.addr), {offset_bits{1'b0}}};
  assign wr_data_valid = state == wb_data;
  assign wr_data       = wb_buf[word_bits-1:0];   // Lowest word goes first
  assign wr_data_last  = (state == wb_data) && beat_last;

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  dcache_pkg::cpu_req_t  req,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output dcache_pkg::word_t     rsp_data,
  input  logic                  rsp_ready,
  output logic                  rd_req_valid,
  output dcache_pkg::addr_t     rd_req_addr,
  input  logic                  rd_req_ready,
  input  logic                  rd_rsp_valid,
  input  dcache_pkg::word_t     rd_rsp_data,
  input  logic                  rd_rsp_last,
  output logic                  rd_rsp_ready,
  output logic                  wr_req_valid,
  output dcache_pkg::addr_t     wr_req_addr,
  input  logic                  wr_req_ready,
  output logic                  wr_data_valid,
  output dcache_pkg::word_t     wr_data,
  output logic                  wr_data_last,
  input  logic                  wr_data_ready
);
  import dcache_pkg::*;

  lookup_t                   lookup;
  tag_t [way_count-1:0]      way_tags;
  way_t                      victim;
  store_cmd_t                cmd;
  logic                      touch;
  way_t                      touch_way;

  // Tags, flags and line data
  way_store u_store (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .cmd       (cmd),
    .fill_data (rd_rsp_data),                     // Refill beats go straight in
    .lookup    (lookup),
    .way_tags  (way_tags)
  );

  // Victim choice in parallel with the lookup
  lru_select u_lru (
    .clk       (clk),
    .rst       (rst),
    .index     (addr_index(req.addr)),
    .touch     (touch),
    .touch_way (touch_way),
    .victim    (victim)
  );

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_ready     (rsp_ready),
    .lookup        (lookup),
    .way_tags      (way_tags),
    .victim        (victim),
    .cmd           (cmd),
    .touch         (touch),
    .touch_way     (touch_way),
    .rd_req_valid  (rd_req_valid),
    .rd_req_addr   (rd_req_addr),
    .rd_req_ready  (rd_req_ready),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_data   (rd_rsp_data),
    .rd_rsp_last   (rd_rsp_last),
    .rd_rsp_ready  (rd_rsp_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_addr   (wr_req_addr),
    .wr_req_ready  (wr_req_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data       (wr_data),
    .wr_data_last  (wr_data_last),
    .wr_data_ready (wr_data_ready)
  );

endmodule

`default_nettype wire

// ==== verif/dcache_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_properties (
  input logic               clk,
  input logic               rst,
  input logic               rsp_valid,
  input logic               rsp_ready,
  input dcache_pkg::word_t  rsp_data,
  input logic               rd_req_valid,
  input logic               rd_req_ready,
  input dcache_pkg::addr_t  rd_req_addr,
  input logic               wr_req_valid,
  input logic               wr_req_ready,
  input dcache_pkg::addr_t  wr_req_addr,
  input logic               wr_data_valid,
  input logic               wr_data_ready,
  input logic               wr_data_last
);

  logic [2:0] wr_beats;                           // Accepted write beats, wraps per burst

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_beats <= '0;
    end else if (wr_data_valid && wr_data_ready) begin
      wr_beats <= wr_beats + 1'b1;
    end
  end

  // Response held under back-pressure
  rsp_hold: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else $error("rsp_valid dropped or rsp_data changed before rsp_ready");

  rd_req_hold: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr))
    else $error("read request dropped or changed before rd_req_ready");

  wr_req_hold: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req_addr))
    else $error("write request dropped or changed before wr_req_ready");

  // Last on every eighth accepted beat and nowhere else
  wr_last_beat: assert property (@(posedge clk) disable iff (rst)
    wr_data_valid && wr_data_ready |-> wr_data_last == (wr_beats == 3'd7))
    else $error("wr_data_last does not match the beat count");

  no_req_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !rd_req_valid && !wr_req_valid && !wr_data_valid)
    else $error("memory request valid in the cycle after reset");

endmodule

bind dcache_top dcache_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .rsp_valid     (rsp_valid),
  .rsp_ready     (rsp_ready),
  .rsp_data      (rsp_data),
  .rd_req_valid  (rd_req_valid),
  .rd_req_ready  (rd_req_ready),
  .rd_req_addr   (rd_req_addr),
  .wr_req_valid  (wr_req_valid),
  .wr_req_ready  (wr_req_ready),
  .wr_req_addr   (wr_req_addr),
  .wr_data_valid (wr_data_valid),
  .wr_data_ready (wr_data_ready),
  .wr_data_last  (wr_data_last)
);

`default_nettype wire

// ==== verif/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
  import dcache_pkg::*;

  localparam int    clk_period   = 40;
  localparam int    req_budget   = 200;           // Requests covered by the watchdog
  localparam int    req_cycles   = 60;            // Allowance per request
  localparam int    random_reqs  = 180;
  localparam word_t fill_pattern = 32'h5a5a_5a5a; // Memory content of unwritten words

  logic     clk;
  logic     rst;
  logic     req_valid;
  cpu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  word_t    rsp_data;
  logic     rsp_ready;

  logic  rd_req_valid;
  addr_t rd_req_addr;
  logic  rd_req_ready = 1'b0;
  logic  rd_rsp_valid = 1'b0;
  word_t rd_rsp_data  = '0;
  logic  rd_rsp_last  = 1'b0;
  logic  rd_rsp_ready;
  logic  wr_req_valid;
  addr_t wr_req_addr;
  logic  wr_req_ready = 1'b0;
  logic  wr_data_valid;
  word_t wr_data;
  logic  wr_data_last;
  logic  wr_data_ready = 1'b0;

  int    error_count   = 0;
  int    rd_req_count  = 0;                       // Accepted refill requests
  int    wr_req_count  = 0;                       // Accepted write-back requests
  int    wb_beat_count = 0;
  int    rd_at_wb      = 0;                       // Refill count when the last write-back began
  addr_t last_wb_addr  = '0;

  word_t mem_words [addr_t];                      // Memory model, written words only
  word_t ref_words [addr_t];                      // Expected CPU view of memory

  // Memory read channel
  logic       rd_busy = 1'b0;
  addr_t      rd_base = '0;
  logic [3:0] rd_beat = '0;
  logic [3:0] rd_next;
  logic [1:0] rd_wait = '0;
  // Memory write channel
  logic       wr_busy = 1'b0;
  addr_t      wr_base = '0;
  logic [2:0] wr_beat = '0;
  logic [1:0] wr_wait = '0;

  dcache_top UUT (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .rsp_ready     (rsp_ready),
    .rd_req_valid  (rd_req_valid),
    .rd_req_addr   (rd_req_addr),
    .rd_req_ready  (rd_req_ready),
    .rd_rsp_valid  (rd_rsp_valid),
    .rd_rsp_data   (rd_rsp_data),
    .rd_rsp_last   (rd_rsp_last),
    .rd_rsp_ready  (rd_rsp_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req_addr   (wr_req_addr),
    .wr_req_ready  (wr_req_ready),
    .wr_data_valid (wr_data_valid),
    .wr_data       (wr_data),
    .wr_data_last  (wr_data_last),
    .wr_data_ready (wr_data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(req_budget * req_cycles * clk_period);
    $display("Watchdog expired, the DUT stopped answering requests");
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic word_t untouched_word(addr_t a);
    return a ^ fill_pattern;
  endfunction

  function automatic word_t memory_word(addr_t a);
    if (mem_words.exists(a)) begin
      return mem_words[a];
    end
    return untouched_word(a);
  endfunction

  function automatic word_t expected_word(addr_t a);
    if (ref_words.exists(a)) begin
      return ref_words[a];
    end
    return untouched_word(a);
  endfunction

  // Only the enabled bytes take the new data
  function automatic word_t apply_strobes(word_t old, word_t wdata, strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t make_addr(tag_t tag, index_t set, logic [2:0] word);
    return {tag, set, word, 2'b00};               // Tag, set index, word, byte
  endfunction

  // Read channel, ready after a random delay, beats with random gaps
  always @(posedge clk) begin
    if (rst) begin
      rd_req_ready <= 1'b0;
      rd_rsp_valid <= 1'b0;
      rd_rsp_last  <= 1'b0;
      rd_busy      <= 1'b0;
      rd_beat      <= '0;
      rd_wait      <= '0;
    end else begin
      rd_next = rd_beat;
      rd_req_ready <= 1'b0;
      if (rd_req_valid && rd_req_ready) begin
        rd_busy      <= 1'b1;
        rd_base      <= rd_req_addr;
        rd_next      = '0;
        rd_wait      <= 2'($urandom_range(0, 3));  // Delay for the next request
        rd_req_count <= rd_req_count + 1;
      end else if (rd_req_valid && !rd_busy) begin
        if (rd_wait != 2'd0) begin
          rd_wait <= rd_wait - 1'b1;
        end else begin
          rd_req_ready <= 1'b1;
        end
      end
      if (rd_rsp_valid && rd_rsp_ready) begin
        rd_next = rd_beat + 1'b1;                 // Beat taken at this edge
      end
      rd_beat <= rd_next;
      if (rd_busy && (rd_next < 4'd8) && ($urandom_range(0, 3) != 0)) begin
        rd_rsp_valid <= 1'b1;
        rd_rsp_data  <= memory_word(rd_base + addr_t'({rd_next, 2'b00}));
        rd_rsp_last  <= rd_next == 4'd7;
      end else begin
        rd_rsp_valid <= 1'b0;
        rd_rsp_last  <= 1'b0;
      end
      if (rd_next == 4'd8) begin
        rd_busy <= 1'b0;                          // Burst complete
      end
    end
  end

  // Write channel, beats stored in order from the request address
  always @(posedge clk) begin
    if (rst) begin
      wr_req_ready  <= 1'b0;
      wr_data_ready <= 1'b0;
      wr_busy       <= 1'b0;
      wr_beat       <= '0;
      wr_wait       <= '0;
    end else begin
      wr_req_ready  <= 1'b0;
      wr_data_ready <= ($urandom_range(0, 3) != 0);  // Random stalls
      if (wr_req_valid && wr_req_ready) begin
        wr_busy      <= 1'b1;
        wr_base      <= wr_req_addr;
        wr_beat      <= '0;
        wr_wait      <= 2'($urandom_range(0, 3));
        wr_req_count <= wr_req_count + 1;
        last_wb_addr <= wr_req_addr;
        rd_at_wb     <= rd_req_count;
      end else if (wr_req_valid && !wr_busy) begin
        if (wr_wait != 2'd0) begin
          wr_wait <= wr_wait - 1'b1;
        end else begin
          wr_req_ready <= 1'b1;
        end
      end
      if (wr_data_valid && wr_data_ready) begin
        mem_words[wr_base + addr_t'({wr_beat, 2'b00})] = wr_data;
        wr_beat       <= wr_beat + 1'b1;
        wb_beat_count <= wb_beat_count + 1;
        if (wr_data_last) begin
          wr_busy <= 1'b0;
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_cond(input string what, input logic ok);
    assert (ok === 1'b1) else begin
      error_count++;
      $display("Check failed: %s", what);
    end
  endtask

  task automatic check_quiet(input string name);
    check_cond($sformatf("%s, a handshake output is high", name),
               !req_ready && !rsp_valid && !rd_req_valid && !wr_req_valid &&
               !wr_data_valid && !rd_rsp_ready);
  endtask

  // One CPU request, held until req_ready; reads also wait for the response
  task automatic cpu_access(input logic write, input addr_t addr, input word_t wdata,
                            input strb_t strb, output word_t rdata, output int cycles);
    cpu_req_t r;
    logic     got;
    r.write = write;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = strb;
    rdata   = '0;
    cycles  = 0;
    got     = 1'b0;
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
    end while (!req_ready);
    req_valid <= 1'b0;
    while (!write && !got) begin
      @(posedge clk);
      if (rsp_valid && rsp_ready) begin
        got   = 1'b1;
        rdata = rsp_data;
      end
      rsp_ready <= ($urandom_range(0, 2) != 0);  // Back-pressure about one cycle in three
    end
  endtask

  task automatic read_check(input string name, input addr_t addr, output int cycles);
    word_t data;
    cpu_access(1'b0, addr, '0, '0, data, cycles);
    check_value(name, expected_word(addr), data);
  endtask

  task automatic write_word(input addr_t addr, input word_t data, input strb_t strb);
    word_t unused;
    int    cycles;
    cpu_access(1'b1, addr, data, strb, unused, cycles);
    ref_words[addr] = apply_strobes(expected_word(addr), data, strb);
  endtask

  initial begin
    addr_t addr_a;
    addr_t addr;
    addr_t lru_addr [5];
    int    cycles;
    int    rd_before;
    int    wr_before;
    int    beats_before;
    void'($urandom(32'hdb9e_190b));
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;

    repeat (2) @(posedge clk);
    check_quiet("during reset");
    rst <= 1'b0;
    @(posedge clk);
    check_quiet("first cycle after reset");

    // Cold read, then a hit in the same line
    addr_a = make_addr(24'h000010, 3'd0, 3'd2);
    read_check("cold read", addr_a, cycles);
    rd_before = rd_req_count;
    wr_before = wr_req_count;
    read_check("same line read", addr_a + 32'd4, cycles);
    check_value("hit ready latency", 32'd2, cycles);  // Idle cycle, then the ready cycle
    check_value("memory reads on hit", rd_before, rd_req_count);
    check_value("memory writes on hit", wr_before, wr_req_count);

    write_word(addr_a + 32'd8, 32'hc0de_beef, 4'b0101);
    read_check("strobed write", addr_a + 32'd8, cycles);

    // Set 6: B is written, then A reread, so B is the oldest and dirty
    for (int t = 0; t < 5; t++) begin
      lru_addr[t] = make_addr(tag_t'(24'h0000a1 + t), 3'd6, 3'd3);
    end
    read_check("lru fill A", lru_addr[0], cycles);
    write_word(lru_addr[1], 32'h1234_5678, 4'b1111);
    read_check("lru fill C", lru_addr[2], cycles);
    read_check("lru fill D", lru_addr[3], cycles);
    read_check("lru reread A", lru_addr[0], cycles);
    rd_before    = rd_req_count;
    wr_before    = wr_req_count;
    beats_before = wb_beat_count;
    read_check("lru fill E", lru_addr[4], cycles);
    check_value("write-back count", wr_before + 1, wr_req_count);
    check_value("write-back address", lru_addr[1] & 32'hffff_ffe0, last_wb_addr);
    check_value("write-back beats", beats_before + 8, wb_beat_count);
    check_value("refill after write-back", rd_before, rd_at_wb);
    check_value("write-back data", 32'h1234_5678, memory_word(lru_addr[1]));
    read_check("evicted B from memory", lru_addr[1], cycles);

    // Mixed traffic over sets 1 to 3 and six tags
    for (int i = 0; i < random_reqs; i++) begin
      addr = make_addr(tag_t'(24'h000300 + $urandom_range(0, 5)),
                       index_t'(1 + $urandom_range(0, 2)),
                       3'($urandom_range(0, 7)));
      if ($urandom_range(0, 1) == 1) begin
        write_word(addr, $urandom, strb_t'($urandom_range(0, 15)));
      end else begin
        read_check("random read", addr, cycles);
      end
    end

    repeat (4) @(posedge clk);
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
source/dcache_pkg.sv
source/cache_array.sv
source/way_store.sv
source/lru_select.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verif/dcache_properties.sv
verif/tb_dcache.sv

// ==== Makefile ====
TOP := tb_dcache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f project.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
